/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_pipeline_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Verification passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# pass only if the pass message shows up on a line of its own
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* design/decode_stage.sv */
/*
  unsupported or invalid words leave as all-zero control (a bubble)
  register file has no reset, x0 always reads zero
  a writeback in the same cycle is seen by the read
*/
`timescale 1ns/1ps

module decode_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rv_pkg::XLEN-1:0]       if_instr,
    input  logic                          if_valid,
    hazard_if.decode                      hz,
    input  logic                          wb_we,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic [rv_pkg::XLEN-1:0]       wb_value,
    output rv_pkg::ex_ctrl_t              id_ctrl,
    output logic [rv_pkg::XLEN-1:0]       id_a,
    output logic [rv_pkg::XLEN-1:0]       id_b,
    output logic [rv_pkg::XLEN-1:0]       id_imm,
    output logic [rv_pkg::REG_ADDR_W-1:0] id_rs1,
    output logic [rv_pkg::REG_ADDR_W-1:0] id_rs2
);

    logic [6:0]                    opcode, funct7;
    logic [2:0]                    funct3;
    logic [rv_pkg::REG_ADDR_W-1:0] rd, rs1, rs2;
    logic [rv_pkg::XLEN-1:0]       imm_i, imm_s, dec_imm;
    rv_pkg::alu_op_e               f3_op;
    logic                          f3_ok, use_rs1, use_rs2;
    rv_pkg::ex_ctrl_t              dec_ctrl;
    logic [rv_pkg::XLEN-1:0]       regs [2**rv_pkg::REG_ADDR_W];

    assign opcode = if_instr[6:0];
    assign rd     = if_instr[11:7];
    assign funct3 = if_instr[14:12];
    assign rs1    = if_instr[19:15];
    assign rs2    = if_instr[24:20];
    assign funct7 = if_instr[31:25];
    assign imm_i  = {{20{if_instr[31]}}, if_instr[31:20]};
    assign imm_s  = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};

    // funct3 is shared by the register and immediate ALU forms
    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            rv_pkg::F3_ADD: f3_op = rv_pkg::ALU_ADD;
            rv_pkg::F3_SLT: f3_op = rv_pkg::ALU_SLT;
            rv_pkg::F3_XOR: f3_op = rv_pkg::ALU_XOR;
            rv_pkg::F3_OR:  f3_op = rv_pkg::ALU_OR;
            rv_pkg::F3_AND: f3_op = rv_pkg::ALU_AND;
            default: begin
                f3_op = rv_pkg::ALU_ADD;
                f3_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        dec_ctrl = '0;
        dec_imm  = imm_i;
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        if (if_valid) begin
            case (opcode)
                rv_pkg::OP_REG: begin
                    if (f3_ok && (funct7 == rv_pkg::F7_BASE ||
                                  (funct7 == rv_pkg::F7_SUB && funct3 == rv_pkg::F3_ADD))) begin
                        dec_ctrl.alu_op    = (funct7 == rv_pkg::F7_SUB) ? rv_pkg::ALU_SUB : f3_op;
                        dec_ctrl.reg_write = 1'b1;
                        use_rs1            = 1'b1;
                        use_rs2            = 1'b1;
                    end
                end
                rv_pkg::OP_IMM: begin
                    if (f3_ok) begin
                        dec_ctrl.alu_op    = f3_op;
                        dec_ctrl.use_imm   = 1'b1;
                        dec_ctrl.reg_write = 1'b1;
                        use_rs1            = 1'b1;
                    end
                end
                rv_pkg::OP_LOAD: begin
                    if (funct3 == rv_pkg::F3_WORD) begin
                        dec_ctrl.use_imm   = 1'b1;
                        dec_ctrl.mem_read  = 1'b1;
                        dec_ctrl.reg_write = 1'b1;
                        use_rs1            = 1'b1;
                    end
                end
                rv_pkg::OP_STORE: begin
                    if (funct3 == rv_pkg::F3_WORD) begin
                        dec_imm            = imm_s;
                        dec_ctrl.use_imm   = 1'b1;
                        dec_ctrl.mem_write = 1'b1;
                        use_rs1            = 1'b1;
                        use_rs2            = 1'b1;
                    end
                end
                default: ;
            endcase
        end
        dec_ctrl.reg_write = dec_ctrl.reg_write && (rd != '0);
        dec_ctrl.rd        = dec_ctrl.reg_write ? rd : '0;
    end

    assign hz.id_rs1 = use_rs1 ? rs1 : '0;
    assign hz.id_rs2 = use_rs2 ? rs2 : '0;

    always_ff @(posedge clk) begin
        if (wb_we) begin
            regs[wb_rd] <= wb_value;
        end
    end

    // decode/execute register, bubble on stall
    always_ff @(posedge clk) begin
        if (reset || hz.stall) begin
            id_ctrl <= '0;
        end else begin
            id_ctrl <= dec_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        id_a   <= (rs1 == '0) ? '0 : (wb_we && wb_rd == rs1) ? wb_value : regs[rs1];
        id_b   <= (rs2 == '0) ? '0 : (wb_we && wb_rd == rs2) ? wb_value : regs[rs2];
        id_imm <= dec_imm;
        id_rs1 <= hz.id_rs1;
        id_rs2 <= hz.id_rs2;
    end

endmodule

/* design/execute_stage.sv */
/*
  operands come from the register value or are forwarded from memory/writeback
  loads and stores compute rs1 + imm with ALU_ADD
  slt compares signed
*/
`timescale 1ns/1ps

module execute_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  rv_pkg::ex_ctrl_t              id_ctrl,
    input  logic [rv_pkg::XLEN-1:0]       id_a,
    input  logic [rv_pkg::XLEN-1:0]       id_b,
    input  logic [rv_pkg::XLEN-1:0]       id_imm,
    input  logic [rv_pkg::REG_ADDR_W-1:0] id_rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] id_rs2,
    hazard_if.execute                     hz,
    input  logic [rv_pkg::XLEN-1:0]       mem_fwd_value,
    input  logic [rv_pkg::XLEN-1:0]       wb_value,
    output rv_pkg::ex_ctrl_t              ex_ctrl,
    output logic [rv_pkg::XLEN-1:0]       alu_result,
    output logic [rv_pkg::XLEN-1:0]       store_data
);

    logic [rv_pkg::XLEN-1:0] op_a, op_b_reg, op_b, alu_out;

    assign hz.ex_rs1       = id_rs1;
    assign hz.ex_rs2       = id_rs2;
    assign hz.ex_rd        = id_ctrl.rd;
    assign hz.ex_reg_write = id_ctrl.reg_write;
    assign hz.ex_mem_read  = id_ctrl.mem_read;

    always_comb begin
        case (hz.fwd_a)
            rv_pkg::FWD_MEM: op_a = mem_fwd_value;
            rv_pkg::FWD_WB:  op_a = wb_value;
            default:         op_a = id_a;
        endcase
        case (hz.fwd_b)
            rv_pkg::FWD_MEM: op_b_reg = mem_fwd_value;
            rv_pkg::FWD_WB:  op_b_reg = wb_value;
            default:         op_b_reg = id_b;
        endcase
    end

    assign op_b = id_ctrl.use_imm ? id_imm : op_b_reg;

    always_comb begin
        case (id_ctrl.alu_op)
            rv_pkg::ALU_SUB: alu_out = op_a - op_b;
            rv_pkg::ALU_AND: alu_out = op_a & op_b;
            rv_pkg::ALU_OR:  alu_out = op_a | op_b;
            rv_pkg::ALU_XOR: alu_out = op_a ^ op_b;
            rv_pkg::ALU_SLT: alu_out = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default:         alu_out = op_a + op_b;
        endcase
    end

    // execute/memory register
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_ctrl <= '0;
        end else begin
            ex_ctrl <= id_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        alu_result <= alu_out;
        store_data <= op_b_reg;  // rs2 after forwarding, for sw
    end

endmodule

/* design/fetch_stage.sv */
/*
  pc counts words and wraps at the end of the 64-word instruction memory
  load the program through prog_we only while run is low
*/
`timescale 1ns/1ps

module fetch_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          run,
    input  logic                          prog_we,
    input  logic [rv_pkg::MEM_ADDR_W-1:0] prog_addr,
    input  logic [rv_pkg::XLEN-1:0]       prog_data,
    input  logic                          stall,
    output logic [rv_pkg::XLEN-1:0]       if_instr,
    output logic                          if_valid
);

    logic [rv_pkg::MEM_ADDR_W-1:0] pc;
    logic [rv_pkg::XLEN-1:0]       imem [rv_pkg::IMEM_DEPTH];

    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // fetch/decode control, held on a load-use stall
    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= '0;
            if_valid <= 1'b0;
        end else if (!stall) begin
            if_valid <= run;  // idle slots decode as bubbles
            if (run) begin
                pc <= pc + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_instr <= imem[pc];
        end
    end

endmodule

/* design/hazard_forward_unit.sv */
/*
  purely combinational
  stall lasts one cycle, the bubble moves the load out of execute
  a load is in writeback by the time its user reaches execute
*/
`timescale 1ns/1ps

module hazard_forward_unit (
    hazard_if.hazard hz
);

    // reg_write is never set for rd == 0, so x0 is never forwarded
    function automatic rv_pkg::fwd_sel_e pick_src(input logic [rv_pkg::REG_ADDR_W-1:0] rs);
        if (hz.mem_reg_write && hz.mem_rd == rs) begin
            return rv_pkg::FWD_MEM;  // newest value wins
        end else if (hz.wb_reg_write && hz.wb_rd == rs) begin
            return rv_pkg::FWD_WB;
        end
        return rv_pkg::FWD_REG;
    endfunction

    assign hz.stall = hz.ex_mem_read && hz.ex_reg_write &&
                      (hz.ex_rd == hz.id_rs1 || hz.ex_rd == hz.id_rs2);

    always_comb begin
        hz.fwd_a = pick_src(hz.ex_rs1);
        hz.fwd_b = pick_src(hz.ex_rs2);
    end

endmodule

/* design/hazard_if.sv */
/*
  register numbers and write flags from the stages to the hazard unit,
  stall and forwarding selects back to decode and execute
*/
`timescale 1ns/1ps

interface hazard_if;

    logic [rv_pkg::REG_ADDR_W-1:0] id_rs1, id_rs2;  // zero when the source is unused
    logic                          stall;

    logic [rv_pkg::REG_ADDR_W-1:0] ex_rs1, ex_rs2, ex_rd;
    logic                          ex_reg_write, ex_mem_read;
    rv_pkg::fwd_sel_e              fwd_a, fwd_b;

    logic [rv_pkg::REG_ADDR_W-1:0] mem_rd, wb_rd;
    logic                          mem_reg_write, wb_reg_write;

    modport decode (output id_rs1, id_rs2, input stall);
    modport execute (output ex_rs1, ex_rs2, ex_rd, ex_reg_write, ex_mem_read,
                     input fwd_a, fwd_b);
    modport memwb (output mem_rd, mem_reg_write, wb_rd, wb_reg_write);
    modport hazard (input id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, ex_reg_write,
                    ex_mem_read, mem_rd, mem_reg_write, wb_rd, wb_reg_write,
                    output stall, fwd_a, fwd_b);

endinterface

/* design/mem_writeback_stage.sv */
/*
  64-word data memory, no reset, word address from alu_result[7:2]
  the load word is read on the edge into the memory/writeback register
*/
`timescale 1ns/1ps

module mem_writeback_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  rv_pkg::ex_ctrl_t              ex_ctrl,
    input  logic [rv_pkg::XLEN-1:0]       alu_result,
    input  logic [rv_pkg::XLEN-1:0]       store_data,
    hazard_if.memwb                       hz,
    output logic [rv_pkg::XLEN-1:0]       mem_fwd_value,
    output logic                          wb_we,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [rv_pkg::XLEN-1:0]       wb_value
);

    logic [rv_pkg::XLEN-1:0]       dmem [rv_pkg::DMEM_DEPTH];
    logic [rv_pkg::MEM_ADDR_W-1:0] addr;
    logic [rv_pkg::XLEN-1:0]       wb_load, wb_alu;
    logic                          wb_mem_read;

    assign addr          = alu_result[rv_pkg::MEM_ADDR_W+1:2];
    assign mem_fwd_value = alu_result;  // loads never forward from here
    assign hz.mem_rd        = ex_ctrl.rd;
    assign hz.mem_reg_write = ex_ctrl.reg_write;

    always_ff @(posedge clk) begin
        if (ex_ctrl.mem_write) begin
            dmem[addr] <= store_data;
        end
        if (ex_ctrl.mem_read) begin
            wb_load <= dmem[addr];
        end
        wb_alu <= alu_result;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_we       <= 1'b0;
            wb_rd       <= '0;
            wb_mem_read <= 1'b0;
        end else begin
            wb_we       <= ex_ctrl.reg_write;
            wb_rd       <= ex_ctrl.rd;
            wb_mem_read <= ex_ctrl.mem_read;
        end
    end

    assign wb_value        = wb_mem_read ? wb_load : wb_alu;
    assign hz.wb_rd        = wb_rd;
    assign hz.wb_reg_write = wb_we;

endmodule

/* design/rv_pipeline_top.sv */
/*
  five-stage RV32I subset core: ALU ops, immediates, lw and sw
  program the instruction memory with run low, then raise run
  retire_* pulses once per write to a nonzero register, in program order
*/
`timescale 1ns/1ps

module rv_pipeline_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          run,
    input  logic                          prog_we,
    input  logic [rv_pkg::MEM_ADDR_W-1:0] prog_addr,
    input  logic [rv_pkg::XLEN-1:0]       prog_data,
    output logic                          retire_valid,
    output logic [rv_pkg::REG_ADDR_W-1:0] retire_rd,
    output logic [rv_pkg::XLEN-1:0]       retire_value
);

    logic [rv_pkg::XLEN-1:0]       if_instr, id_a, id_b, id_imm;
    logic                          if_valid, wb_we;
    logic [rv_pkg::REG_ADDR_W-1:0] id_rs1, id_rs2, wb_rd;
    rv_pkg::ex_ctrl_t              id_ctrl, ex_ctrl;
    logic [rv_pkg::XLEN-1:0]       alu_result, store_data, mem_fwd_value, wb_value;

    hazard_if hz ();

    fetch_stage fetch_i (
        .clk(clk), .reset(reset), .run(run), .prog_we(prog_we),
        .prog_addr(prog_addr), .prog_data(prog_data), .stall(hz.stall),
        .if_instr(if_instr), .if_valid(if_valid)
    );

    decode_stage decode_i (
        .clk(clk), .reset(reset), .if_instr(if_instr), .if_valid(if_valid), .hz(hz.decode),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_value(wb_value),
        .id_ctrl(id_ctrl), .id_a(id_a), .id_b(id_b), .id_imm(id_imm),
        .id_rs1(id_rs1), .id_rs2(id_rs2)
    );

    hazard_forward_unit hazard_i (.hz(hz.hazard));

    execute_stage execute_i (
        .clk(clk), .reset(reset), .id_ctrl(id_ctrl), .id_a(id_a), .id_b(id_b),
        .id_imm(id_imm), .id_rs1(id_rs1), .id_rs2(id_rs2), .hz(hz.execute),
        .mem_fwd_value(mem_fwd_value), .wb_value(wb_value),
        .ex_ctrl(ex_ctrl), .alu_result(alu_result), .store_data(store_data)
    );

    mem_writeback_stage memwb_i (
        .clk(clk), .reset(reset), .ex_ctrl(ex_ctrl), .alu_result(alu_result),
        .store_data(store_data), .hz(hz.memwb), .mem_fwd_value(mem_fwd_value),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_value(wb_value)
    );

    assign retire_valid = wb_we;
    assign retire_rd    = wb_rd;
    assign retire_value = wb_value;

endmodule

/* design/rv_pkg.sv */
/*
  shared widths and encodings for the five-stage RV32I subset core
  only add/sub/and/or/xor/slt, their immediate forms, lw and sw are decoded
  memories are word addressed, byte address bits 7:2
*/
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;
    localparam int MEM_ADDR_W = 6;

    // funct3 and funct7 values used by the decoder
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010;  // lw / sw
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_IMM   = 7'b0010011,
        OP_STORE = 7'b0100011,
        OP_REG   = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,  // zero so a cleared control word adds
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_e;

    // all zero is a bubble
    typedef struct packed {
        alu_op_e                alu_op;
        logic                   use_imm;
        logic                   mem_read;
        logic                   mem_write;
        logic                   reg_write;  // never set with rd == 0
        logic [REG_ADDR_W-1:0]  rd;
    } ex_ctrl_t;

endpackage

/* tb.f */
design/rv_pkg.sv
design/hazard_if.sv
design/fetch_stage.sv
design/decode_stage.sv
design/hazard_forward_unit.sv
design/execute_stage.sv
design/mem_writeback_stage.sv
design/rv_pipeline_top.sv
tests/rv_pipeline_tb.sv

/* tests/rv_pipeline_tb.sv */
/*
  short programs run on rv_pipeline_top, each retirement checked against an ISA model
  register file and data memory keep their state across tests, so one test sets every register
  programs stay under 40 words so pc never wraps inside a test
*/
`timescale 1ns/1ps

module rv_pipeline_tb;

    typedef struct packed {
        logic [rv_pkg::REG_ADDR_W-1:0] rd;
        logic [rv_pkg::XLEN-1:0]       value;
    } retire_t;

    logic                          clk, reset, run, prog_we, retire_valid;
    logic [rv_pkg::MEM_ADDR_W-1:0] prog_addr;
    logic [rv_pkg::XLEN-1:0]       prog_data, retire_value;
    logic [rv_pkg::REG_ADDR_W-1:0] retire_rd;

    logic [rv_pkg::XLEN-1:0] prog [rv_pkg::IMEM_DEPTH];
    logic [rv_pkg::XLEN-1:0] mregs [32];                 // model state
    logic [rv_pkg::XLEN-1:0] mdmem [rv_pkg::DMEM_DEPTH];
    retire_t                 exp_q [$];                  // all expected writes, never popped
    int                      rd_idx, check_errors;       // owned by the checker
    int                      prog_len, test_errors, check_base, errors, passed, failed;
    bit                      hung;
    string                   test_name;

    rv_pipeline_top rv_pipeline_top_i (
        .clk(clk), .reset(reset), .run(run), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .retire_valid(retire_valid), .retire_rd(retire_rd),
        .retire_value(retire_value)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // retirements must follow the model queue in order
    always @(negedge clk) begin
        if (!reset && retire_valid) begin
            assert (rd_idx < exp_q.size()) else begin
                $display("unexpected retirement of x%0d in test %s", retire_rd, test_name);
                check_errors++;
            end
            if (rd_idx < exp_q.size()) begin
                assert (retire_rd == exp_q[rd_idx].rd && retire_value == exp_q[rd_idx].value)
                else begin
                    $display("ERR %s expected x%0d=%08h actual x%0d=%08h", test_name,
                             exp_q[rd_idx].rd, exp_q[rd_idx].value, retire_rd, retire_value);
                    check_errors++;
                end
                rd_idx++;
            end
        end
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rd, rs1,
                                           input logic [4:0] rs2, input logic [2:0] f3);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rd, rs1,
                                           input logic [2:0] f3, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs1, rs2,
                                           input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OP_STORE};
    endfunction

    // {supported, result} for the shared R and I funct3 field
    function automatic logic [32:0] alu_ref(input logic [2:0] f3, input logic sub,
                                            input logic [31:0] a, b);
        case (f3)
            3'b000:  return {1'b1, sub ? a - b : a + b};
            3'b010:  return {1'b1, 31'd0, $signed(a) < $signed(b)};
            3'b100:  return {1'b1, a ^ b};
            3'b110:  return {1'b1, a | b};
            3'b111:  return {1'b1, a & b};
            default: return 33'd0;
        endcase
    endfunction

    // 0 add, 1 and, 2 or, 3 xor, 4 slt, 5 and up fall back to 000
    function automatic logic [2:0] alu_f3(input int k);
        case (k)
            1:       return 3'b111;
            2:       return 3'b110;
            3:       return 3'b100;
            4:       return 3'b010;
            default: return 3'b000;
        endcase
    endfunction

    task automatic model_step(input logic [31:0] w);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a, b, imm_i, imm_s, ea;
        logic [32:0] res;
        rd    = w[11:7];
        f3    = w[14:12];
        a     = mregs[w[19:15]];
        b     = mregs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        res   = 33'd0;
        case (w[6:0])
            rv_pkg::OP_REG: begin
                if (w[31:25] == 7'h00 || (w[31:25] == 7'h20 && f3 == 3'b000)) begin
                    res = alu_ref(f3, w[30], a, b);
                end
            end
            rv_pkg::OP_IMM: res = alu_ref(f3, 1'b0, a, imm_i);
            rv_pkg::OP_LOAD: begin
                ea = a + imm_i;
                if (f3 == 3'b010) begin
                    res = {1'b1, mdmem[ea[7:2]]};
                end
            end
            rv_pkg::OP_STORE: begin
                ea = a + imm_s;
                if (f3 == 3'b010) begin
                    mdmem[ea[7:2]] = b;
                end
            end
            default: ;  // no effect
        endcase
        if (res[32] && rd != 5'd0) begin
            mregs[rd] = res[31:0];
            exp_q.push_back({rd, res[31:0]});
        end
    endtask

    task automatic emit(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic rand_r(input logic [4:0] rd, rs1, rs2);
        int k;
        k = $urandom_range(5);
        emit(r_type((k == 5) ? 7'h20 : 7'h00, rd, rs1, rs2, alu_f3(k)));  // 5 is sub
    endtask

    task automatic rand_i(input logic [4:0] rd, rs1);
        logic [11:0] imm;
        imm = 12'($urandom_range(4095));
        emit(i_type(imm, rd, rs1, alu_f3($urandom_range(4)), rv_pkg::OP_IMM));
    endtask

    task automatic rand_op(input logic [4:0] rd, rs1, rs2);
        if ($urandom_range(1) == 1) begin
            rand_r(rd, rs1, rs2);
        end else begin
            rand_i(rd, rs1);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic load_program();
        for (int i = 0; i < rv_pkg::IMEM_DEPTH; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= 6'(i);
            prog_data <= (i < prog_len) ? prog[i] : '0;  // tail of zero words
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    task automatic run_program();
        int cycles;
        apply_reset();
        load_program();
        for (int i = 0; i < prog_len; i++) begin
            model_step(prog[i]);
        end
        @(posedge clk);
        run    <= 1'b1;
        cycles = 0;
        while (rd_idx < exp_q.size() && cycles < 200) begin
            @(posedge clk);
            cycles++;
        end
        if (rd_idx < exp_q.size()) begin
            $display("timeout: %0d retirements never arrived in test %s",
                     exp_q.size() - rd_idx, test_name);
            test_errors++;
            hung = 1'b1;
        end
        repeat (8) @(posedge clk);  // trailing stores drain
        run <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        check_base  = check_errors;
        prog_len    = 0;
    endtask

    task automatic finish_test();
        int n;
        n = test_errors + check_errors - check_base;
        if (n == 0) begin
            passed++;
        end else begin
            failed++;
        end
        errors += n;
        $display("test %-12s %s, %0d errors", test_name, (n == 0) ? "ok" : "FAILED", n);
    endtask

    task automatic test_idle();
        int seen;
        start_test("idle");
        seen = 0;
        // writing instructions sit in memory, but run stays low
        for (int r = 1; r < 32; r++) begin
            emit(i_type(12'(r), 5'(r), 0, 3'b000, rv_pkg::OP_IMM));
        end
        apply_reset();
        load_program();
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            if (retire_valid) begin
                seen++;
            end
        end
        assert (seen == 0) else begin
            $display("ERR %s expected 0 retirements actual %0d", test_name, seen);
            test_errors++;
        end
    endtask

    task automatic test_dependent();
        start_test("dependent");
        for (int d = 1; d <= 3; d++) begin
            for (int side = 0; side < 2; side++) begin
                rand_op(5, 10, 11);
                for (int f = 1; f < d; f++) begin
                    rand_i(5'(19 + f), 12);  // filler, no link to x5
                end
                if (side == 0) begin
                    rand_op(6, 5, 13);
                end else begin
                    rand_r(6, 14, 5);
                end
            end
        end
        for (int i = 0; i < 4; i++) begin
            rand_op(7, 7, 8);
            rand_op(7, 7, 8);
            rand_r(8, 7, 8);  // x7 in memory and writeback at once
        end
        run_program();
    endtask

    task automatic test_load_store();
        logic [11:0] a;
        start_test("load_store");
        for (int k = 0; k < 5; k++) begin
            a = 12'(4 * $urandom_range(63));
            rand_i(15, 17);
            emit(s_type(a, 0, 15, 3'b010));  // store data from the memory stage
            emit(i_type(a, 16, 0, 3'b010, rv_pkg::OP_LOAD));
            rand_r(17, 16, 11);                // load-use on rs1
            emit(i_type(a, 18, 0, 3'b010, rv_pkg::OP_LOAD));
            rand_r(19, 12, 18);                // load-use on rs2
        end
        run_program();
    endtask

    task automatic test_x0();
        start_test("x0");
        emit(s_type(12'h0, 0, 10, 3'b010));
        for (int k = 0; k < 4; k++) begin
            rand_op(0, 10, 11);
            rand_r(20, 0, 11);
            rand_i(21, 0);
            emit(i_type(12'h0, 0, 0, 3'b010, rv_pkg::OP_LOAD));
            rand_r(22, 12, 0);
        end
        run_program();
    endtask

    task automatic test_unsupported();
        start_test("unsupported");
        rand_i(22, 10);
        for (int k = 0; k < 10; k++) begin
            case (k)
                0: emit(32'h0000_0000);
                1: emit(32'hffff_ffff);
                2: emit(r_type(7'h00, 22, 10, 11, 3'b001));               // sll
                3: emit(r_type(7'h20, 22, 10, 11, 3'b111));
                4: emit(r_type(7'h01, 22, 10, 11, 3'b000));               // mul
                5: emit(i_type(12'h7ff, 22, 10, 3'b011, rv_pkg::OP_IMM)); // sltiu
                6: emit(i_type(12'h0, 22, 0, 3'b000, rv_pkg::OP_LOAD));   // lb
                7: emit(s_type(12'h0, 0, 10, 3'b000));                    // sb
                8: emit(32'h1234_5b37);                                   // lui x22
                default: emit(32'h0020_8463);                             // beq
            endcase
            rand_r(23, 22, 13);
        end
        run_program();
    endtask

    initial begin
        void'($urandom(99682));
        reset        = 1'b1;
        run          = 1'b0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        mregs[0]     = '0;
        rd_idx       = 0;
        check_errors = 0;
        errors       = 0;
        passed       = 0;
        failed       = 0;
        hung         = 1'b0;
        for (int t = 0; t < 7 && !hung; t++) begin
            case (t)
                0: test_idle();
                1: begin
                    start_test("reg_init");
                    for (int r = 1; r < 32; r++) begin
                        emit(i_type(12'($urandom_range(4095)), 5'(r), 0, 3'b000, rv_pkg::OP_IMM));
                    end
                    run_program();
                end
                2: begin
                    start_test("alu_random");
                    for (int i = 0; i < 36; i++) begin
                        rand_op(5'($urandom_range(31, 1)), 5'($urandom_range(31)),
                                5'($urandom_range(31)));
                    end
                    run_program();
                end
                3: test_dependent();
                4: test_load_store();
                5: test_x0();
                default: test_unsupported();
            endcase
            finish_test();
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 passed + failed, passed, failed, errors);
        if (errors == 0 && !hung) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
